// ==== common/dataMemPkg.sv ====
package dataMemPkg;

    // Bits per memory cell
    localparam int ByteWidth = 8;

    // Bytes moved by one word access
    localparam int WordBytes = 4;

    // One memory cell
    typedef logic [ByteWidth-1:0] byteT;

    // One bus data word in little-endian byte lanes
    typedef logic [ByteWidth*WordBytes-1:0] wordT;

    // Slave controller states
    typedef enum logic
    {
        IDLE,
        ACK
    } wbStateT;

endpackage

// ==== dataMem/wbSlaveCtrl.sv ====
`timescale 1ns/1ps

module wbSlaveCtrl
(
    input  logic clk,
    input  logic rst,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    output logic ack,
    output logic commitWrite,
    output logic commitRead
);

    import dataMemPkg::*;

    wbStateT state;
    wbStateT nextState;

    // New transfer seen while idle
    logic request;

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        nextState = state;
        case (state)
            IDLE:
            begin
                if (cyc && stb)
                begin
                    nextState = ACK;
                end
            end
            ACK:
            begin
                // Single-cycle ack
                nextState = IDLE;
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    assign request = (state == IDLE) && cyc && stb;

    // Commit lands on the edge that raises ack
    assign commitWrite = request && we;
    assign commitRead  = request && !we;

    assign ack = (state == ACK);

endmodule

// ==== dataMem/byteStore.sv ====
`timescale 1ns/1ps

module byteStore
#(
    parameter int AddrWidth = 5
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 commitWrite,
    input  logic [AddrWidth-1:0] adr,
    input  logic                 byteAccess,
    input  dataMemPkg::wordT     datIn,
    output dataMemPkg::byteT     cellsAtAdr0,
    output dataMemPkg::byteT     cellsAtAdr1,
    output dataMemPkg::byteT     cellsAtAdr2,
    output dataMemPkg::byteT     cellsAtAdr3
);

    import dataMemPkg::*;

    localparam int Depth = 2 ** AddrWidth;

    typedef logic [AddrWidth-1:0] adrT;

    byteT mem [Depth];

    // Cell index for each byte lane of a word access
    adrT laneAdr [WordBytes];

    // Little-endian data byte for each lane
    byteT laneData [WordBytes];

    ////////////////////////////////////////////////////////////////////////////
    // Lane steering
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < WordBytes; g++)
    begin : gLane
        // Adding in AddrWidth bits wraps past the top cell
        assign laneAdr[g]  = adr + adrT'(g);
        assign laneData[g] = datIn[g*ByteWidth +: ByteWidth];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte array
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < Depth; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (commitWrite)
        begin
            if (byteAccess)
            begin
                // Only the addressed cell changes
                mem[adr] <= laneData[0];
            end
            else
            begin
                for (int b = 0; b < WordBytes; b++)
                begin
                    mem[laneAdr[b]] <= laneData[b];
                end
            end
        end
    end

    // Read side is always the four cells from adr upward
    assign cellsAtAdr0 = mem[laneAdr[0]];
    assign cellsAtAdr1 = mem[laneAdr[1]];
    assign cellsAtAdr2 = mem[laneAdr[2]];
    assign cellsAtAdr3 = mem[laneAdr[3]];

endmodule

// ==== dataMem/readAligner.sv ====
`timescale 1ns/1ps

module readAligner
(
    input  logic             clk,
    input  logic             rst,
    input  logic             commitRead,
    input  logic             byteAccess,
    input  dataMemPkg::byteT cellsAtAdr0,
    input  dataMemPkg::byteT cellsAtAdr1,
    input  dataMemPkg::byteT cellsAtAdr2,
    input  dataMemPkg::byteT cellsAtAdr3,
    output dataMemPkg::wordT datOut
);

    import dataMemPkg::*;

    // Upper bits filled on a byte read
    localparam int PadWidth = ByteWidth * (WordBytes - 1);

    wordT byteWord;
    wordT fullWord;
    wordT readWord;

    ////////////////////////////////////////////////////////////////////////////
    // Assembly
    ////////////////////////////////////////////////////////////////////////////

    // Zero-extended single cell
    assign byteWord = {{PadWidth{1'b0}}, cellsAtAdr0};

    // Lowest address ends up in bits 7:0
    assign fullWord = {cellsAtAdr3, cellsAtAdr2, cellsAtAdr1, cellsAtAdr0};

    assign readWord = byteAccess ? byteWord : fullWord;

    ////////////////////////////////////////////////////////////////////////////
    // Read register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            datOut <= '0;
        end
        else if (commitRead)
        begin
            // Valid from the edge that raises ack
            datOut <= readWord;
        end
    end

endmodule

// ==== dataMem/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory
#(
    parameter int AddrWidth = 5
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [AddrWidth-1:0] adr,
    input  logic                 byteAccess,
    input  dataMemPkg::wordT     datIn,
    output dataMemPkg::wordT     datOut,
    output logic                 ack
);

    import dataMemPkg::*;

    logic commitWrite;
    logic commitRead;

    // Four wrapped cells starting at adr
    byteT cellsAtAdr0;
    byteT cellsAtAdr1;
    byteT cellsAtAdr2;
    byteT cellsAtAdr3;

    ////////////////////////////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////////////////////////////

    wbSlaveCtrl busCtrl
    (
        .clk         (clk),
        .rst         (rst),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .ack         (ack),
        .commitWrite (commitWrite),
        .commitRead  (commitRead)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage and read path
    ////////////////////////////////////////////////////////////////////////////

    byteStore
    #(
        .AddrWidth (AddrWidth)
    )
    store
    (
        .clk         (clk),
        .rst         (rst),
        .commitWrite (commitWrite),
        .adr         (adr),
        .byteAccess  (byteAccess),
        .datIn       (datIn),
        .cellsAtAdr0 (cellsAtAdr0),
        .cellsAtAdr1 (cellsAtAdr1),
        .cellsAtAdr2 (cellsAtAdr2),
        .cellsAtAdr3 (cellsAtAdr3)
    );

    readAligner aligner
    (
        .clk         (clk),
        .rst         (rst),
        .commitRead  (commitRead),
        .byteAccess  (byteAccess),
        .cellsAtAdr0 (cellsAtAdr0),
        .cellsAtAdr1 (cellsAtAdr1),
        .cellsAtAdr2 (cellsAtAdr2),
        .cellsAtAdr3 (cellsAtAdr3),
        .datOut      (datOut)
    );

endmodule

// ==== verif/dataMemory_assert.sv ====
`timescale 1ns/1ps

module dataMemoryAssert
(
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack
);

    ////////////////////////////////////////////////////////////////////////////
    // Bus protocol
    ////////////////////////////////////////////////////////////////////////////

    // Slave starts quiet
    ackLowAfterReset: assert property (@(posedge clk) rst |=> !ack)
        else $error("ack high in the cycle after reset");

    // One-cycle ack per transfer
    ackSingleCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // No ack without a request
    ackAfterRequest: assert property
    (
        @(posedge clk) disable iff (rst) ack |-> $past(cyc && stb)
    )
        else $error("ack without cyc and stb in the previous cycle");

endmodule

bind dataMemory dataMemoryAssert busChecks
(
    .clk (clk),
    .rst (rst),
    .cyc (cyc),
    .stb (stb),
    .ack (ack)
);

// ==== verif/dataMemoryTb.sv ====
`timescale 1ns/1ps

module dataMemoryTb;

    import dataMemPkg::*;

    localparam int AddrWidth   = 5;
    localparam int ResetCycles = 5;
    localparam int MaxEntries  = 128;
    localparam int EntryWidth  = 80;
    localparam string TraceFile = "verif/dataMemoryTrace.txt";

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic                 byteAccess;
    wordT                 datIn;
    wordT                 datOut;
    logic                 ack;

    // op, size, adr, write data, expected read data
    logic [EntryWidth-1:0] trace [MaxEntries];

    int          entryCount;
    int          cycleLimit;
    int          cycleCount;
    int          errorCount;
    int          checkCount;
    logic [31:0] lcgState;

    // Value datOut must hold between reads
    wordT lastRead;

    dataMemory
    #(
        .AddrWidth (AddrWidth)
    )
    dut
    (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .byteAccess (byteAccess),
        .datIn      (datIn),
        .datOut     (datOut),
        .ack        (ack)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and run limit
    ////////////////////////////////////////////////////////////////////////////

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Run timed out after %0d cycles before the trace was done", cycleCount);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic loadTrace();
        for (int i = 0; i < MaxEntries; i++)
        begin
            trace[i] = '1;
        end
        $readmemh(TraceFile, trace);
        entryCount = 0;
        // Op nibble F marks the end
        while (entryCount < MaxEntries && trace[entryCount][79:76] != 4'hf)
        begin
            entryCount++;
        end
        if (entryCount == 0)
        begin
            errorCount++;
            $display("Trace file %s held no transfers", TraceFile);
        end
    endtask

    // Starts on a falling edge and ends on the one after ack drops
    task automatic runTransfer(input logic [EntryWidth-1:0] entry);
        logic isWrite;
        logic isByte;
        wordT expected;
        int   waitCycles;
        isWrite    = (entry[79:76] == 4'h1);
        isByte     = (entry[75:72] == 4'h1);
        expected   = entry[31:0];
        cyc        = 1'b1;
        stb        = 1'b1;
        we         = isWrite;
        adr        = entry[64 +: AddrWidth];
        byteAccess = isByte;
        datIn      = entry[63:32];
        waitCycles = 0;
        do
        begin
            @(negedge clk);
            waitCycles++;
        end
        while (!ack);
        checkValue("ackLatency", 32'd1, waitCycles);
        if (isWrite)
        begin
            checkValue("datOut", lastRead, datOut);
        end
        else
        begin
            checkValue("datOut", expected, datOut);
            lastRead = expected;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);
        checkValue("ack", 32'd0, ack);
        checkValue("datOut", lastRead, datOut);
    endtask

    task automatic idleGap();
        int gap;
        lcgState = lcgNext(lcgState);
        gap = lcgState[17:16];
        repeat (gap)
        begin
            @(negedge clk);
            checkValue("ack", 32'd0, ack);
            checkValue("datOut", lastRead, datOut);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        byteAccess = 1'b0;
        datIn      = '0;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        cycleLimit = MaxEntries * 7 + ResetCycles + 20;
        lastRead   = '0;
        lcgState   = 32'd80155;

        loadTrace();
        cycleLimit = entryCount * 7 + ResetCycles + 20;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("ack", 32'd0, ack);
        checkValue("datOut", 32'd0, datOut);

        for (int i = 0; i < entryCount; i++)
        begin
            runTransfer(trace[i]);
            idleGap();
        end

        $display("Transfers: %0d  checks: %0d  errors: %0d", entryCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verif/dataMemoryTrace.txt ====
// op (1 write, 0 read) _ size (1 byte, 0 word) _ adr _ write data _ expected read data
// An entry with op f ends the list
// Reset leaves every cell zero
0_1_00_00000000_00000000
0_0_00_00000000_00000000
0_0_1c_00000000_00000000
0_1_1f_00000000_00000000
0_0_1e_00000000_00000000
0_1_0a_00000000_00000000
// Word round trip, little-endian placement
1_0_04_44332211_00000000
0_0_04_00000000_44332211
0_1_05_00000000_00000022
0_1_07_00000000_00000044
0_0_05_00000000_00443322
1_0_10_a1b2c3d4_00000000
0_0_10_00000000_a1b2c3d4
0_1_11_00000000_000000c3
0_1_13_00000000_000000a1
// Byte writes touch one cell only
1_1_06_123456ab_00000000
0_0_04_00000000_44ab2211
0_1_06_00000000_000000ab
0_0_03_00000000_ab221100
1_1_12_ffffff5a_00000000
0_0_10_00000000_a15ac3d4
0_1_11_00000000_000000c3
0_1_13_00000000_000000a1
0_0_0f_00000000_5ac3d400
// Word accesses wrap past the top cell
1_0_1e_87654321_00000000
0_1_00_00000000_00000065
0_1_01_00000000_00000087
0_1_1e_00000000_00000021
0_1_1f_00000000_00000043
0_0_1e_00000000_87654321
0_0_1f_00000000_00876543
0_0_1d_00000000_65432100
1_0_1f_0f0e0d0c_00000000
0_0_1e_00000000_0e0d0c21
0_0_00_00000000_000f0e0d
0_1_02_00000000_0000000f
1_1_1f_00000099_00000000
0_0_1e_00000000_0e0d9921
0_1_1f_00000000_00000099
0_1_00_00000000_0000000d
// Writes between reads, datOut holds
1_0_08_cafef00d_00000000
1_1_09_00000077_00000000
0_0_08_00000000_cafe770d
0_0_06_00000000_770d44ab
0_1_0a_00000000_000000fe
0_0_0c_00000000_00000000
1_0_04_01020304_00000000
0_0_04_00000000_01020304
0_0_02_00000000_0304000f
0_1_05_00000000_00000003
f_f_00_00000000_00000000

// ==== verilog.f ====
common/dataMemPkg.sv
dataMem/wbSlaveCtrl.sv
dataMem/byteStore.sv
dataMem/readAligner.sv
dataMem/dataMemory.sv
verif/dataMemory_assert.sv
verif/dataMemoryTb.sv
